// File: list.f
src/keccak_pkg.sv
src/keccak_theta_rho_pi.sv
src/keccak_chi_iota.sv
src/keccak_permute.sv
src/keccak_apb_regs.sv
src/keccak_apb_top.sv
tb/tb_clk_gen.sv
tb/keccak_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module keccak_tb \
  --Mdir obj_dir \
  -o keccak_sim \
  -f list.f

sim_out=$(./obj_dir/keccak_sim)
echo "$sim_out"

if grep -qF 'All tests passed!' <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// File: tb/keccak_tb.sv
`default_nettype none
`timescale 1ns/1ps

module keccak_tb
  import keccak_pkg::*;
();

  localparam int Width      = 200;
  localparam int LaneW      = 8;
  localparam int Rounds     = 18;
  localparam int StateWords = 7;
  // Six tests of a few dozen APB transfers plus 18-cycle runs need well under 1000
  localparam int TimeoutCycles = 3000;

  logic     clk;
  logic     rst_n;
  apb_req_t req;
  apb_rsp_t rsp;
  int       seed = 2334;
  int       pass_cnt;
  int       fail_cnt;
  int       test_base;
  int       cycle_cnt;

  tb_clk_gen clk_gen_inst (
    .clk_o (clk)
  );

  keccak_apb_top #(
    .Width (Width)
  ) keccak_apb_top_inst (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .apb_req_i (req),
    .apb_rsp_o (rsp)
  );

  ////////////////////////////////////////
  // Reference Keccak-f[200]
  ////////////////////////////////////////

  function automatic logic [7:0] rotl8(input logic [7:0] v, input int n);
    logic [15:0] dbl;
    // Upper byte of the doubled lane is the rotation
    dbl = {v, v} << n;
    return dbl[15:8];
  endfunction

  function automatic logic [Width-1:0] keccak_f200(input logic [Width-1:0] s_in);
    logic [7:0]       a [5][5];
    logic [7:0]       b [5][5];
    logic [7:0]       c [5];
    logic [7:0]       d [5];
    logic [Width-1:0] s_out;
    // Lane [x][y] at bit 8*(5y+x)
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        a[x][y] = s_in[LaneW * (5 * y + x) +: LaneW];
      end
    end
    for (int r = 0; r < Rounds; r++) begin
      // Theta
      for (int x = 0; x < 5; x++) begin
        c[x] = a[x][0] ^ a[x][1] ^ a[x][2] ^ a[x][3] ^ a[x][4];
      end
      for (int x = 0; x < 5; x++) begin
        d[x] = c[(x + 4) % 5] ^ rotl8(c[(x + 1) % 5], 1);
      end
      // Rho and pi together move A[x][y] to B[y][2x+3y]
      for (int x = 0; x < 5; x++) begin
        for (int y = 0; y < 5; y++) begin
          b[y][(2 * x + 3 * y) % 5] = rotl8(a[x][y] ^ d[x], RhoOffset[5 * x + y] % LaneW);
        end
      end
      // Chi
      for (int x = 0; x < 5; x++) begin
        for (int y = 0; y < 5; y++) begin
          a[x][y] = b[x][y] ^ (~b[(x + 1) % 5][y] & b[(x + 2) % 5][y]);
        end
      end
      // Iota
      a[0][0] = a[0][0] ^ RoundConst[r][LaneW-1:0];
    end
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        s_out[LaneW * (5 * y + x) +: LaneW] = a[x][y];
      end
    end
    return s_out;
  endfunction

  ////////////////////////////////////////
  // Checks and bookkeeping
  ////////////////////////////////////////

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    if (actual !== expected) begin
      $display("error at %0t ns: %s, got %h expected %h", $time, msg, actual, expected);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic begin_test();
    test_base = fail_cnt;
  endtask

  task automatic end_test(input string name);
    if (fail_cnt == test_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d check(s) wrong", name, fail_cnt - test_base);
    end
  endtask

  // Hang guard
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Simulation timed out after %0d cycles", cycle_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////
  // APB driving
  ////////////////////////////////////////

  // Called 1 ns after a rising edge
  // Returns 1 ns after the access edge
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic err);
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = 1'b1;
    req.paddr   = addr;
    req.pwdata  = data;
    @(posedge clk);
    #1;
    req.penable = 1'b1;
    // Response settled by mid access cycle
    #1;
    err = rsp.pslverr;
    check_eq(32'(rsp.pready), 32'd1, "pready in write access cycle");
    @(posedge clk);
    #1;
    req = '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = 1'b0;
    req.paddr   = addr;
    req.pwdata  = '0;
    @(posedge clk);
    #1;
    req.penable = 1'b1;
    #1;
    data = rsp.prdata;
    err  = rsp.pslverr;
    check_eq(32'(rsp.pready), 32'd1, "pready in read access cycle");
    @(posedge clk);
    #1;
    req = '0;
  endtask

  function automatic logic [7:0] word_addr(input int k);
    return RegState + 8'(4 * k);
  endfunction

  task automatic random_state(output logic [Width-1:0] s);
    logic [StateWords*32-1:0] wide;
    for (int k = 0; k < StateWords; k++) begin
      wide[32 * k +: 32] = $random(seed);
    end
    s = wide[Width-1:0];
  endtask

  task automatic write_state(input logic [Width-1:0] s);
    logic [StateWords*32-1:0] wide;
    logic                     err;
    wide            = '0;
    wide[Width-1:0] = s;
    for (int k = 0; k < StateWords; k++) begin
      apb_write(word_addr(k), wide[32 * k +: 32], err);
      check_eq(32'(err), 32'd0, $sformatf("pslverr on state write %0d", k));
    end
  endtask

  task automatic read_state(output logic [Width-1:0] s);
    logic [StateWords*32-1:0] wide;
    logic [31:0]              data;
    logic                     err;
    for (int k = 0; k < StateWords; k++) begin
      apb_read(word_addr(k), data, err);
      check_eq(32'(err), 32'd0, $sformatf("pslverr on state read %0d", k));
      wide[32 * k +: 32] = data;
    end
    s = wide[Width-1:0];
  endtask

  task automatic check_state(input logic [Width-1:0] actual, input logic [Width-1:0] expected,
                             input string what);
    logic [StateWords*32-1:0] act_w;
    logic [StateWords*32-1:0] exp_w;
    act_w            = '0;
    exp_w            = '0;
    act_w[Width-1:0] = actual;
    exp_w[Width-1:0] = expected;
    for (int k = 0; k < StateWords; k++) begin
      check_eq(act_w[32 * k +: 32], exp_w[32 * k +: 32], $sformatf("%s word %0d", what, k));
    end
  endtask

  task automatic start_perm();
    logic err;
    apb_write(RegCtrl, 32'h1, err);
    check_eq(32'(err), 32'd0, "pslverr on start");
  endtask

  // Poll STATUS until done
  task automatic wait_done();
    logic [31:0] st;
    logic        err;
    st = '0;
    while (!st[1]) begin
      apb_read(RegStatus, st, err);
    end
    check_eq(st, 32'h2, "status after done");
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_reset_values();
    logic [31:0] data;
    logic        err;
    begin_test();
    // Idle bus gives a quiet response
    check_eq(32'(rsp.pslverr), 32'd0, "pslverr while idle after reset");
    check_eq(rsp.prdata, 32'h0, "prdata while idle after reset");
    apb_read(RegStatus, data, err);
    check_eq(data, 32'h0, "status after reset");
    for (int k = 0; k < StateWords; k++) begin
      apb_read(word_addr(k), data, err);
      check_eq(data, 32'h0, $sformatf("state word %0d after reset", k));
    end
    end_test("reset_values");
  endtask

  task automatic test_state_readback();
    logic [31:0] words [StateWords];
    logic [31:0] data;
    logic        err;
    begin_test();
    for (int k = 0; k < StateWords; k++) begin
      words[k] = $random(seed);
      apb_write(word_addr(k), words[k], err);
    end
    // Last word holds only bits 199:192
    for (int k = 0; k < StateWords; k++) begin
      apb_read(word_addr(k), data, err);
      check_eq(data, (k == StateWords - 1) ? (words[k] & 32'hFF) : words[k],
               $sformatf("readback word %0d", k));
    end
    end_test("state_readback");
  endtask

  task automatic test_zero_permute();
    logic [Width-1:0] result;
    logic [31:0]      st;
    logic             err;
    begin_test();
    write_state('0);
    start_perm();
    apb_read(RegStatus, st, err);
    check_eq(st, 32'h1, "status right after start");
    wait_done();
    read_state(result);
    check_state(result, keccak_f200('0), "zero state");
    end_test("zero_permute");
  endtask

  task automatic test_random_permute();
    logic [Width-1:0] s;
    logic [Width-1:0] result;
    begin_test();
    for (int i = 0; i < 3; i++) begin
      random_state(s);
      write_state(s);
      start_perm();
      wait_done();
      read_state(result);
      check_state(result, keccak_f200(s), $sformatf("random state %0d", i));
    end
    end_test("random_permute");
  endtask

  task automatic test_error_responses();
    logic [Width-1:0] s;
    logic [Width-1:0] result;
    logic [31:0]      data;
    logic             err;
    begin_test();
    apb_read(8'h08, data, err);
    check_eq(32'(err), 32'd1, "pslverr on unmapped read");
    apb_read(word_addr(StateWords), data, err);
    check_eq(32'(err), 32'd1, "pslverr on word past the state");
    // Write into a running engine is refused and leaves the state alone
    random_state(s);
    write_state(s);
    start_perm();
    apb_write(word_addr(0), 32'hDEAD_BEEF, err);
    check_eq(32'(err), 32'd1, "pslverr on state write while busy");
    wait_done();
    read_state(result);
    check_state(result, keccak_f200(s), "state after refused write");
    end_test("error_responses");
  endtask

  task automatic test_restart();
    logic [Width-1:0] s;
    logic [Width-1:0] result;
    logic [31:0]      st;
    logic             err;
    begin_test();
    random_state(s);
    write_state(s);
    start_perm();
    wait_done();
    // Second run starts from the permuted state
    start_perm();
    apb_read(RegStatus, st, err);
    check_eq(st, 32'h1, "done cleared by restart");
    wait_done();
    read_state(result);
    check_state(result, keccak_f200(keccak_f200(s)), "double permutation");
    end_test("restart");
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    req       = '0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    test_base = 0;
    cycle_cnt = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_values();
    test_state_readback();
    test_zero_permute();
    test_random_permute();
    test_error_responses();
    test_restart();

    $display("checks: %0d matched, %0d mismatched", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HalfPeriod = 2
) (
  output logic clk_o
);

  // 4 ns period, starts low
  initial clk_o = 1'b0;

  always #(HalfPeriod) clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: src/keccak_apb_top.sv
`default_nettype none
`timescale 1ns/1ps

module keccak_apb_top
  import keccak_pkg::*;
#(
  parameter int Width = 200
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o
);

  // Register block to engine
  logic             start;
  state_load_t      load;
  // Engine back to register block
  logic             busy;
  logic             done;
  logic [Width-1:0] perm_state;

  keccak_apb_regs #(
    .Width (Width)
  ) u_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .busy_i    (busy),
    .done_i    (done),
    .state_i   (perm_state),
    .start_o   (start),
    .load_o    (load)
  );

  keccak_permute #(
    .Width (Width)
  ) u_permute (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (start),
    .load_i  (load),
    .busy_o  (busy),
    .done_o  (done),
    .state_o (perm_state)
  );

endmodule

`default_nettype wire

// File: src/keccak_apb_regs.sv
`default_nettype none
`timescale 1ns/1ps

module keccak_apb_regs
  import keccak_pkg::*;
#(
  parameter  int Width      = 200,
  localparam int StateWords = (Width + ApbDataW - 1) / ApbDataW
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  apb_req_t         apb_req_i,
  output apb_rsp_t         apb_rsp_o,
  input  logic             busy_i,
  input  logic             done_i,
  input  logic [Width-1:0] state_i,
  output logic             start_o,
  output state_load_t      load_o
);

  // Decoded target, captured in the setup phase
  typedef struct packed {
    logic                ctrl;
    logic                status;
    logic                state;
    logic [WordIdxW-1:0] idx;
  } dec_t;

  dec_t                           dec_d;
  dec_t                           dec_q;
  logic                           setup;
  logic                           access;
  logic                           wr_access;
  logic                           rd_access;
  logic [ApbAddrW-1:0]            state_off;
  logic                           mapped;
  logic                           state_wr_busy;
  logic [StateWords*ApbDataW-1:0] rd_buf;
  logic [ApbDataW-1:0]            rd_data;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign setup  = apb_req_i.psel & ~apb_req_i.penable;
  assign access = apb_req_i.psel & apb_req_i.penable;

  // Byte offset into the state window
  assign state_off = apb_req_i.paddr - RegState;

  always_comb begin
    dec_d.ctrl   = (apb_req_i.paddr == RegCtrl);
    dec_d.status = (apb_req_i.paddr == RegStatus);
    dec_d.idx    = state_off[ApbAddrW-1:2];
    // Word aligned, inside the window, below StateWords
    dec_d.state  = (apb_req_i.paddr >= RegState) && (state_off[1:0] == 2'b00) &&
                   (int'(dec_d.idx) < StateWords);
  end

  // PADDR is stable from setup to access
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_q <= '0;
    end else if (setup) begin
      dec_q <= dec_d;
    end
  end

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////

  assign wr_access     = access & apb_req_i.pwrite;
  assign rd_access     = access & ~apb_req_i.pwrite;
  assign state_wr_busy = wr_access & dec_q.state & busy_i;

  // Start while busy is dropped quietly
  assign start_o = wr_access & dec_q.ctrl & apb_req_i.pwdata[0] & ~busy_i;

  // Loads only while idle
  assign load_o.valid = wr_access & dec_q.state & ~busy_i;
  assign load_o.index = dec_q.idx;
  assign load_o.data  = apb_req_i.pwdata;

  ////////////////////////////////////////
  // Read side and response
  ////////////////////////////////////////

  always_comb begin
    // Zero above Width in the last word
    rd_buf            = '0;
    rd_buf[Width-1:0] = state_i;
    rd_data           = '0;
    if (dec_q.status) begin
      rd_data = ApbDataW'({done_i, busy_i});
    end else if (dec_q.state) begin
      rd_data = rd_buf[dec_q.idx * ApbDataW +: ApbDataW];
    end
  end

  assign mapped = dec_q.ctrl | dec_q.status | dec_q.state;

  // Zero wait states
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = access & (~mapped | state_wr_busy);
  assign apb_rsp_o.prdata  = rd_access ? rd_data : '0;

endmodule

`default_nettype wire

// File: src/keccak_permute.sv
`default_nettype none
`timescale 1ns/1ps

module keccak_permute
  import keccak_pkg::*;
#(
  parameter  int Width      = 200,
  localparam int L          = $clog2(Width / 25),
  localparam int MaxRound   = 12 + 2 * L,
  localparam int RndW       = $clog2(MaxRound + 1),
  localparam int StateWords = (Width + ApbDataW - 1) / ApbDataW
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             start_i,
  input  state_load_t      load_i,
  output logic             busy_o,
  output logic             done_o,
  output logic [Width-1:0] state_o
);

  perm_state_e                    fsm_q, fsm_d;
  logic [RndW-1:0]                rnd_q, rnd_d;
  logic                           done_q, done_d;
  logic [Width-1:0]               state_q, state_d;
  logic [Width-1:0]               phase1;
  logic [Width-1:0]               round_out;
  logic [StateWords*ApbDataW-1:0] load_buf;
  logic                           last_rnd;

  ////////////////////////////////////////
  // One full round per clock
  ////////////////////////////////////////

  keccak_theta_rho_pi #(
    .Width (Width)
  ) u_phase1 (
    .state_i (state_q),
    .state_o (phase1)
  );

  keccak_chi_iota #(
    .Width (Width)
  ) u_phase2 (
    .state_i (phase1),
    .rnd_i   (rnd_q),
    .state_o (round_out)
  );

  assign last_rnd = (rnd_q == RndW'(MaxRound - 1));

  // Word merge, padding above Width falls away
  always_comb begin
    load_buf                                      = '0;
    load_buf[Width-1:0]                           = state_q;
    load_buf[load_i.index * ApbDataW +: ApbDataW] = load_i.data;
  end

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_comb begin
    fsm_d   = fsm_q;
    rnd_d   = rnd_q;
    done_d  = done_q;
    state_d = state_q;
    unique case (fsm_q)
      PermIdle: begin
        // Start wins over a same-cycle load
        if (start_i) begin
          fsm_d  = PermRun;
          rnd_d  = '0;
          done_d = 1'b0;
        end else if (load_i.valid) begin
          state_d = load_buf[Width-1:0];
        end
      end
      PermRun: begin
        state_d = round_out;
        rnd_d   = rnd_q + 1'b1;
        // Done goes up as busy drops
        if (last_rnd) begin
          fsm_d  = PermIdle;
          rnd_d  = '0;
          done_d = 1'b1;
        end
      end
      default: fsm_d = PermIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fsm_q   <= PermIdle;
      rnd_q   <= '0;
      done_q  <= 1'b0;
      state_q <= '0;
    end else begin
      fsm_q   <= fsm_d;
      rnd_q   <= rnd_d;
      done_q  <= done_d;
      state_q <= state_d;
    end
  end

  assign busy_o  = (fsm_q == PermRun);
  assign done_o  = done_q;
  assign state_o = state_q;

endmodule

`default_nettype wire

// File: src/keccak_chi_iota.sv
`default_nettype none
`timescale 1ns/1ps

module keccak_chi_iota
  import keccak_pkg::*;
#(
  parameter  int Width    = 200,
  localparam int W        = Width / 25,
  localparam int L        = $clog2(W),
  localparam int MaxRound = 12 + 2 * L,
  // Round index range 0..MaxRound
  localparam int RndW     = $clog2(MaxRound + 1)
) (
  input  logic [Width-1:0] state_i,
  input  logic [RndW-1:0]  rnd_i,
  output logic [Width-1:0] state_o
);

  // Same [y][x] lane order as phase 1
  typedef logic [4:0][4:0][W-1:0] box_t;

  box_t         a_in;
  box_t         chi_out;
  box_t         iota_out;
  logic [W-1:0] rc_lane;

  assign a_in = state_i;

  // Chi, nonlinear mix along each row
  always_comb begin
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        chi_out[y][x] = a_in[y][x] ^ (~a_in[y][(x + 1) % 5] & a_in[y][(x + 2) % 5]);
      end
    end
  end

  // Round constant truncated to lane width
  assign rc_lane = RoundConst[rnd_i][W-1:0];

  // Iota only touches lane (0,0)
  always_comb begin
    iota_out       = chi_out;
    iota_out[0][0] = chi_out[0][0] ^ rc_lane;
  end

  assign state_o = iota_out;

endmodule

`default_nettype wire

// File: src/keccak_theta_rho_pi.sv
`default_nettype none
`timescale 1ns/1ps

module keccak_theta_rho_pi
  import keccak_pkg::*;
#(
  parameter  int Width = 200,
  localparam int W     = Width / 25
) (
  input  logic [Width-1:0] state_i,
  output logic [Width-1:0] state_o
);

  // Box indexed [y][x], so flat bit W*(5y+x)+z lines up directly
  typedef logic [4:0][4:0][W-1:0] box_t;
  typedef logic [4:0][W-1:0]      plane_t;

  box_t   a_in;
  box_t   theta_out;
  box_t   rho_out;
  box_t   pi_out;
  plane_t col_par;
  plane_t col_mix;

  assign a_in = state_i;

  ////////////////////////////////////////
  // Theta
  ////////////////////////////////////////

  always_comb begin
    // Column parities over all five rows
    for (int x = 0; x < 5; x++) begin
      col_par[x] = a_in[0][x] ^ a_in[1][x] ^ a_in[2][x] ^ a_in[3][x] ^ a_in[4][x];
    end
    // Left column plus right column shifted up one bit in z
    for (int x = 0; x < 5; x++) begin
      for (int z = 0; z < W; z++) begin
        col_mix[x][z] = col_par[(x + 4) % 5][z] ^ col_par[(x + 1) % 5][(z + W - 1) % W];
      end
    end
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        theta_out[y][x] = a_in[y][x] ^ col_mix[x];
      end
    end
  end

  ////////////////////////////////////////
  // Rho
  ////////////////////////////////////////

  // Fixed per-lane rotate left, offsets folded at elaboration
  for (genvar y = 0; y < 5; y++) begin : g_rho_y
    for (genvar x = 0; x < 5; x++) begin : g_rho_x
      localparam int Offset = RhoOffset[5 * x + y] % W;
      if (Offset == 0) begin : g_plain
        assign rho_out[y][x] = theta_out[y][x];
      end else begin : g_rot
        assign rho_out[y][x] = {theta_out[y][x][W-Offset-1:0],
                                theta_out[y][x][W-1:W-Offset]};
      end
    end
  end

  ////////////////////////////////////////
  // Pi
  ////////////////////////////////////////

  always_comb begin
    // Lane (x,y) pulls from column PiSource, row x
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        pi_out[y][x] = rho_out[x][PiSource[5 * x + y]];
      end
    end
  end

  assign state_o = pi_out;

endmodule

`default_nettype wire

// File: src/keccak_pkg.sv
`default_nettype none

package keccak_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////

  localparam int ApbAddrW = 8;
  localparam int ApbDataW = 32;
  // Enough for 50 words of a 1600-bit state
  localparam int WordIdxW = 6;

  ////////////////////////////////////////
  // Permutation tables
  ////////////////////////////////////////

  // Iota constants per round, narrow lanes take the low bits
  localparam logic [63:0] RoundConst [24] = '{
    64'h0000_0000_0000_0001,
    64'h0000_0000_0000_8082,
    64'h8000_0000_0000_808A,
    64'h8000_0000_8000_8000,
    64'h0000_0000_0000_808B,
    64'h0000_0000_8000_0001,
    64'h8000_0000_8000_8081,
    64'h8000_0000_0000_8009,
    64'h0000_0000_0000_008A,
    64'h0000_0000_0000_0088,
    64'h0000_0000_8000_8009,
    64'h0000_0000_8000_000A,
    64'h0000_0000_8000_808B,
    64'h8000_0000_0000_008B,
    64'h8000_0000_0000_8089,
    64'h8000_0000_0000_8003,
    64'h8000_0000_0000_8002,
    64'h8000_0000_0000_0080,
    64'h0000_0000_0000_800A,
    64'h8000_0000_8000_000A,
    64'h8000_0000_8000_8081,
    64'h8000_0000_0000_8080,
    64'h0000_0000_8000_0001,
    64'h8000_0000_8000_8008
  };

  // Rho rotation per lane, index 5x+y, reduced mod W at use
  localparam int RhoOffset [25] = '{
      0,  36,   3, 105, 210,
      1, 300,  10,  45,  66,
    190,   6, 171,  15, 253,
     28,  55, 153,  21, 120,
     91, 276, 231, 136,  78
  };

  // Pi source column (x+3y) mod 5, index 5x+y
  // Source row is always the destination x
  localparam int PiSource [25] = '{
    0, 3, 1, 4, 2,
    1, 4, 2, 0, 3,
    2, 0, 3, 1, 4,
    3, 1, 4, 2, 0,
    4, 2, 0, 3, 1
  };

  ////////////////////////////////////////
  // Register map and engine states
  ////////////////////////////////////////

  typedef enum logic [ApbAddrW-1:0] {
    RegCtrl   = 8'h00,
    RegStatus = 8'h04,
    // Window base, word k at base + 4k
    RegState  = 8'h40
  } reg_addr_e;

  typedef enum logic {
    PermIdle = 1'b0,
    PermRun  = 1'b1
  } perm_state_e;

  ////////////////////////////////////////
  // Bus and load bundles
  ////////////////////////////////////////

  typedef struct packed {
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [ApbAddrW-1:0] paddr;
    logic [ApbDataW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                pready;
    logic                pslverr;
    logic [ApbDataW-1:0] prdata;
  } apb_rsp_t;

  // One state word headed for the engine
  typedef struct packed {
    logic                valid;
    logic [WordIdxW-1:0] index;
    logic [ApbDataW-1:0] data;
  } state_load_t;

endpackage

`default_nettype wire
